//--- bench/quant_tb.sv
// Testbench for quant_top with matrix load, block playback and result checks
`timescale 1ns/1ns
`include "quant_params.svh"

module quant_tb;

    localparam int NBLK       = 8;
    localparam int MAX_CYCLES = 16 + NBLK * 40;
    localparam int IW         = $bits(quant_pkg::coef_in_t);
    localparam int RW         = $bits(quant_pkg::recon_t);

    logic                     clk;
    logic                     rst_n;
    logic                     cfg_we_i;
    quant_pkg::coef_idx_t     cfg_idx_i;
    quant_pkg::qstep_t        cfg_q_i;
    quant_pkg::qstep_t        cfg_iq_i;
    quant_pkg::bias_t         cfg_bias_i;
    quant_pkg::thresh_t       cfg_zthresh_i;
    quant_pkg::sharpen_t      cfg_sharpen_i;
    logic                     start_i;
    logic [`QB_COEFS*IW-1:0]  blk_i;
    logic [`QB_COEFS*RW-1:0]  rec_o;
    logic                     nz_o;
    logic                     blk_done_o;
    logic                     coef_valid_o;
    quant_pkg::level_t        coef_o;
    quant_pkg::coef_idx_t     coef_pos_o;
    logic                     coef_last_o;

    // Matrix records, seven ints each: block tag then the six fields
    int                   mrec [$];
    quant_pkg::coef_in_t  blk_in  [NBLK][`QB_COEFS];
    quant_pkg::recon_t    exp_rec [NBLK][`QB_COEFS];
    quant_pkg::level_t    exp_zz  [NBLK][`QB_COEFS];
    bit                   exp_nz  [NBLK];
    int                   nblk;
    int                   cycles = 0;

    quant_top quant_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
        end
    end

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_recon(input string name, input quant_pkg::recon_t exp,
                               input quant_pkg::recon_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input quant_pkg::level_t exp,
                               input quant_pkg::level_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_pos(input string name, input quant_pkg::coef_idx_t exp,
                             input quant_pkg::coef_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t %s expected=%0b actual=%0b",
                                $time, name, exp, act));
        end
    endtask

    // ------------------------------
    // Vector file
    // ------------------------------
    task automatic read_value(input int fd, output int v);
        if ($fscanf(fd, "%d", v) != 1) begin
            abort_run("Vector file ended early or holds a bad number");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    v;
        int    ch;
        string tag;
        fd = $fopen("bench/quant_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open bench/quant_vectors.txt");
        end
        nblk = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                // Rest of a comment line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (tag == "M") begin
                mrec.push_back(nblk);
                for (int j = 0; j < 6; j++) begin
                    read_value(fd, v);
                    mrec.push_back(v);
                end
            end else if (tag == "B" && nblk < NBLK) begin
                for (int j = 0; j < `QB_COEFS; j++) begin
                    read_value(fd, v);
                    blk_in[nblk][j] = quant_pkg::coef_in_t'(v);
                end
                for (int j = 0; j < `QB_COEFS; j++) begin
                    read_value(fd, v);
                    exp_rec[nblk][j] = quant_pkg::recon_t'(v);
                end
                for (int j = 0; j < `QB_COEFS; j++) begin
                    read_value(fd, v);
                    exp_zz[nblk][j] = quant_pkg::level_t'(v);
                end
                read_value(fd, v);
                exp_nz[nblk] = (v != 0);
                nblk++;
            end else begin
                abort_run({"Unexpected or surplus record in vector file: ", tag});
            end
        end
        $fclose(fd);
        if (nblk != NBLK) begin
            abort_run($sformatf("Vector file holds %0d blocks instead of %0d", nblk, NBLK));
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Matrix writes tagged for block b, one strobe per record
    task automatic apply_matrix(input int b);
        bit wrote;
        wrote = 1'b0;
        for (int r = 0; r < mrec.size(); r += 7) begin
            if (mrec[r] == b) begin
                @(posedge clk);
                cfg_we_i      <= 1'b1;
                cfg_idx_i     <= quant_pkg::coef_idx_t'(mrec[r+1]);
                cfg_q_i       <= quant_pkg::qstep_t'(mrec[r+2]);
                cfg_iq_i      <= quant_pkg::qstep_t'(mrec[r+3]);
                cfg_bias_i    <= quant_pkg::bias_t'(mrec[r+4]);
                cfg_zthresh_i <= quant_pkg::thresh_t'(mrec[r+5]);
                cfg_sharpen_i <= quant_pkg::sharpen_t'(mrec[r+6]);
                wrote = 1'b1;
            end
        end
        if (wrote) begin
            @(posedge clk);
            cfg_we_i <= 1'b0;
        end
    endtask

    function automatic logic [`QB_COEFS*IW-1:0] pack_block(input int b);
        logic [`QB_COEFS*IW-1:0] flat;
        for (int k = 0; k < `QB_COEFS; k++) begin
            flat[k*IW +: IW] = blk_in[b][k];
        end
        return flat;
    endfunction

    // Done must come two cycles after the start cycle
    task automatic wait_done(input int first);
        int lat;
        lat = first;
        @(negedge clk);
        while (blk_done_o !== 1'b1) begin
            if (lat >= 8) begin
                abort_run("blk_done_o never came after start_i");
            end else begin
                lat++;
                @(negedge clk);
            end
        end
        if (lat != 2) begin
            abort_run($sformatf("blk_done_o came %0d cycles after start_i instead of 2", lat));
        end
    endtask

    task automatic check_results(input int b);
        for (int k = 0; k < `QB_COEFS; k++) begin
            check_recon($sformatf("rec_o[%0d]", k), exp_rec[b][k], rec_o[k*RW +: RW]);
        end
        check_flag("nz_o", exp_nz[b], nz_o);
    endtask

    task automatic run_spaced(input int b);
        @(posedge clk);
        start_i <= 1'b1;
        blk_i   <= pack_block(b);
        @(posedge clk);
        start_i <= 1'b0;
        wait_done(1);
        check_results(b);
        // Zigzag stream, one level per cycle
        for (int i = 0; i < `QB_COEFS; i++) begin
            @(negedge clk);
            if (i == 0) begin
                check_flag("blk_done_o", 1'b0, blk_done_o);
            end
            check_flag("coef_valid_o", 1'b1, coef_valid_o);
            check_pos("coef_pos_o", quant_pkg::coef_idx_t'(i), coef_pos_o);
            check_level("coef_o", exp_zz[b][i], coef_o);
            check_flag("coef_last_o", i == `QB_COEFS - 1, coef_last_o);
        end
        @(negedge clk);
        check_flag("coef_valid_o", 1'b0, coef_valid_o);
    endtask

    // Two starts on consecutive cycles, parallel outputs only
    task automatic run_pair(input int b);
        @(posedge clk);
        start_i <= 1'b1;
        blk_i   <= pack_block(b);
        @(posedge clk);
        blk_i   <= pack_block(b + 1);
        @(posedge clk);
        start_i <= 1'b0;
        wait_done(2);
        check_results(b);
        @(negedge clk);
        check_flag("blk_done_o", 1'b1, blk_done_o);
        check_results(b + 1);
        while (coef_valid_o === 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        cfg_we_i      = 1'b0;
        cfg_idx_i     = '0;
        cfg_q_i       = '0;
        cfg_iq_i      = '0;
        cfg_bias_i    = '0;
        cfg_zthresh_i = '0;
        cfg_sharpen_i = '0;
        start_i       = 1'b0;
        blk_i         = '0;
        load_vectors();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet outputs right after reset
        @(negedge clk);
        check_flag("blk_done_o", 1'b0, blk_done_o);
        check_flag("coef_valid_o", 1'b0, coef_valid_o);
        check_flag("coef_last_o", 1'b0, coef_last_o);
        check_flag("nz_o", 1'b0, nz_o);
        check_level("coef_o", '0, coef_o);
        for (int k = 0; k < `QB_COEFS; k++) begin
            check_recon($sformatf("rec_o[%0d]", k), '0, rec_o[k*RW +: RW]);
        end
        for (int b = 0; b < 4; b++) begin
            apply_matrix(b);
            run_spaced(b);
        end
        apply_matrix(4);
        run_pair(4);
        for (int b = 6; b < NBLK; b++) begin
            apply_matrix(b);
            run_spaced(b);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- bench/quant_vectors.txt
# M pos q iq bias zthresh sharpen
# B in[16] raster, rec[16] raster, level[16] zigzag, nz
M 0 8 16384 65536 3 0
M 1 16 8192 65536 7 2
M 2 8 16384 65536 3 0
M 3 16 8192 65536 7 2
M 4 8 16384 65536 3 0
M 5 16 8192 65536 7 2
M 6 8 16384 65536 3 0
M 7 16 8192 65536 7 2
M 8 8 16384 65536 3 0
M 9 16 8192 65536 7 2
M 10 8 16384 65536 3 0
M 11 16 8192 65536 7 2
M 12 8 16384 65536 3 0
M 13 16 8192 65536 7 2
M 14 8 16384 65536 3 0
M 15 64 2048 65536 0 0
B 100 50 -37 20 3 -6 0 5 12 -100 4 0 -1 31 255 640 104 48 -40 16 0 -16 0 0 16 -96 8 0 0 32 256 640 13 3 0 2 -1 -5 1 0 -6 0 2 1 0 0 32 10 1
B 20000 -32768 -20000 32767 16379 1000 16380 -1000 -16380 7 -5 -8 32767 0 -4 32767 16376 -32752 -16376 32752 16376 1008 16376 -1008 -16376 16 -8 -16 16376 0 -8 -32768 2047 -2047 2047 -2047 63 -2047 2047 2047 1 2047 0 -1 -63 -1 -1 512 1
B 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
B 3 -5 -3 5 2 4 -2 -4 1 3 -1 -3 0 5 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
B -100 200 0 -50 64 0 -7 0 0 0 0 0 0 0 0 -32768 -104 208 0 -48 64 0 -8 0 0 0 0 0 0 0 0 -32768 -13 13 8 0 0 0 -3 -1 0 0 0 0 0 0 0 -512 1
B 7 0 0 0 0 0 0 0 0 0 0 0 -300 6 0 1 8 0 0 0 0 0 0 0 0 0 0 0 -304 16 0 0 1 0 0 0 0 0 0 0 0 -38 1 0 0 0 0 0 1
M 0 4 32768 65536 10 1
B 9 5 -3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
B -1000 0 1000 0 0 40 0 0 0 0 0 0 0 0 0 100 -1000 0 1000 0 0 48 0 0 0 0 0 0 0 0 0 128 -250 0 0 0 3 125 0 0 0 0 0 0 0 0 0 2 1

//--- design/coef_scan.sv
// Serializer for the zigzag levels of one block, position and last markers
`timescale 1ns/1ns
`include "quant_params.svh"

module coef_scan (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              load_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::level_t)-1:0]    zz_i,
    output logic                                              coef_valid_o,
    output quant_pkg::level_t                                 coef_o,
    output quant_pkg::coef_idx_t                              coef_pos_o,
    output logic                                              coef_last_o
);

    localparam int LW = $bits(quant_pkg::level_t);
    localparam quant_pkg::coef_idx_t LAST_POS = quant_pkg::coef_idx_t'(`QB_COEFS - 1);

    quant_pkg::scan_state_t state;
    quant_pkg::coef_idx_t   cnt;
    quant_pkg::level_t      hold [`QB_COEFS];

    // ------------------------------
    // FSM and position counter
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= quant_pkg::SCAN_IDLE;
            cnt   <= '0;
        end else if (load_i) begin
            // A new block restarts the scan
            state <= quant_pkg::SCAN_RUN;
            cnt   <= '0;
        end else if (state == quant_pkg::SCAN_RUN) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST_POS) begin
                state <= quant_pkg::SCAN_IDLE;
            end
        end
    end

    // ------------------------------
    // Holding register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `QB_COEFS; k++) begin
                hold[k] <= '0;
            end
        end else if (load_i) begin
            for (int k = 0; k < `QB_COEFS; k++) begin
                hold[k] <= zz_i[k*LW +: LW];
            end
        end
    end

    // Stream outputs
    assign coef_valid_o = (state == quant_pkg::SCAN_RUN);
    assign coef_o       = hold[cnt];
    assign coef_pos_o   = cnt;
    assign coef_last_o  = coef_valid_o && (cnt == LAST_POS);

endmodule

//--- design/quant_block.sv
// Two-stage 4x4 block quantizer with dequantized output and zigzag levels
`timescale 1ns/1ns
`include "quant_params.svh"

module quant_block (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              start_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::coef_in_t)-1:0]  blk_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    q_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    iq_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::bias_t)-1:0]     bias_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::thresh_t)-1:0]   zthresh_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::sharpen_t)-1:0]  sharpen_i,
    output logic [`QB_COEFS*$bits(quant_pkg::recon_t)-1:0]    rec_o,
    output logic [`QB_COEFS*$bits(quant_pkg::level_t)-1:0]    zz_o,
    output logic                                              nz_o,
    output logic                                              done_o
);

    localparam int IW = $bits(quant_pkg::coef_in_t);
    localparam int QW = $bits(quant_pkg::qstep_t);
    localparam int BW = $bits(quant_pkg::bias_t);
    localparam int TW = $bits(quant_pkg::thresh_t);
    localparam int HW = $bits(quant_pkg::sharpen_t);
    localparam int LW = $bits(quant_pkg::level_t);
    localparam int RW = $bits(quant_pkg::recon_t);

    // Magnitude plus sharpen, product with iq, then plus bias
    localparam int CW = IW + 1;
    localparam int PW = CW + QW;
    localparam int SW = PW + 1;
    localparam int SHW = SW - `QB_SHIFT;

    // Raster position feeding each zigzag slot
    localparam int ZZ_MAP [`QB_COEFS] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic [1:0] vld;

    // Stage one payload
    logic [SHW-1:0]        lvl_s1  [`QB_COEFS];
    logic                  sign_s1 [`QB_COEFS];
    logic                  keep_s1 [`QB_COEFS];
    quant_pkg::qstep_t     q_s1    [`QB_COEFS];

    // Stage two results, raster order
    quant_pkg::level_t     lvl_s2  [`QB_COEFS];
    quant_pkg::recon_t     rec_s2  [`QB_COEFS];
    logic [`QB_COEFS-1:0]  lvl_nz;

    // ------------------------------
    // Valid pipe, start to done
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[0], start_i};
        end
    end

    assign done_o = vld[1];

    for (genvar k = 0; k < `QB_COEFS; k++) begin : g_pos
        quant_pkg::coef_in_t    x;
        logic                   sign;
        logic [IW-1:0]          mag;
        logic [CW-1:0]          coeff;
        logic [PW-1:0]          prod;
        logic [SW-1:0]          sum;
        logic [SHW-1:0]         clamp;
        quant_pkg::level_t      lvl_mag;
        quant_pkg::level_t      lvl_signed;
        quant_pkg::recon_t      rec_next;

        // ------------------------------
        // Stage one
        // ------------------------------
        assign x     = blk_i[k*IW +: IW];
        assign sign  = x[IW-1];
        // -32768 maps to 32768 as unsigned
        assign mag   = sign ? (~x + 1'b1) : x;
        assign coeff = mag + sharpen_i[k*HW +: HW];
        assign prod  = coeff * iq_i[k*QW +: QW];
        assign sum   = prod + bias_i[k*BW +: BW];

        always_ff @(posedge clk) begin
            if (start_i) begin
                lvl_s1[k]  <= sum[SW-1:`QB_SHIFT];
                sign_s1[k] <= sign;
                keep_s1[k] <= quant_pkg::thresh_t'(coeff) > zthresh_i[k*TW +: TW];
                q_s1[k]    <= q_i[k*QW +: QW];
            end
        end

        // ------------------------------
        // Stage two
        // ------------------------------
        assign clamp      = (lvl_s1[k] > SHW'(`QB_MAX_LEVEL)) ? SHW'(`QB_MAX_LEVEL) : lvl_s1[k];
        assign lvl_mag    = quant_pkg::level_t'(clamp);
        assign lvl_signed = sign_s1[k] ? -lvl_mag : lvl_mag;
        // Low 16 bits of the product only
        assign rec_next   = lvl_signed * q_s1[k];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lvl_s2[k] <= '0;
                rec_s2[k] <= '0;
            end else if (vld[0]) begin
                lvl_s2[k] <= keep_s1[k] ? lvl_signed : '0;
                rec_s2[k] <= keep_s1[k] ? rec_next : '0;
            end
        end

        assign lvl_nz[k]            = (lvl_s2[k] != '0);
        assign rec_o[k*RW +: RW]    = rec_s2[k];
        assign zz_o[k*LW +: LW]     = lvl_s2[ZZ_MAP[k]];
    end

    assign nz_o = |lvl_nz;

endmodule

//--- design/quant_matrix_store.sv
// Quantization matrix register file, one position written per strobe
`timescale 1ns/1ns
`include "quant_params.svh"

module quant_matrix_store (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              cfg_we_i,
    input  quant_pkg::coef_idx_t                              cfg_idx_i,
    input  quant_pkg::qstep_t                                 cfg_q_i,
    input  quant_pkg::qstep_t                                 cfg_iq_i,
    input  quant_pkg::bias_t                                  cfg_bias_i,
    input  quant_pkg::thresh_t                                cfg_zthresh_i,
    input  quant_pkg::sharpen_t                               cfg_sharpen_i,
    output logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    q_o,
    output logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    iq_o,
    output logic [`QB_COEFS*$bits(quant_pkg::bias_t)-1:0]     bias_o,
    output logic [`QB_COEFS*$bits(quant_pkg::thresh_t)-1:0]   zthresh_o,
    output logic [`QB_COEFS*$bits(quant_pkg::sharpen_t)-1:0]  sharpen_o
);

    localparam int QW = $bits(quant_pkg::qstep_t);
    localparam int BW = $bits(quant_pkg::bias_t);
    localparam int TW = $bits(quant_pkg::thresh_t);
    localparam int HW = $bits(quant_pkg::sharpen_t);

    quant_pkg::qstep_t   q_mem       [`QB_COEFS];
    quant_pkg::qstep_t   iq_mem      [`QB_COEFS];
    quant_pkg::bias_t    bias_mem    [`QB_COEFS];
    quant_pkg::thresh_t  zthresh_mem [`QB_COEFS];
    quant_pkg::sharpen_t sharpen_mem [`QB_COEFS];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `QB_COEFS; k++) begin
                q_mem[k]       <= '0;
                iq_mem[k]      <= '0;
                bias_mem[k]    <= '0;
                zthresh_mem[k] <= '0;
                sharpen_mem[k] <= '0;
            end
        end else if (cfg_we_i) begin
            q_mem[cfg_idx_i]       <= cfg_q_i;
            iq_mem[cfg_idx_i]      <= cfg_iq_i;
            bias_mem[cfg_idx_i]    <= cfg_bias_i;
            zthresh_mem[cfg_idx_i] <= cfg_zthresh_i;
            sharpen_mem[cfg_idx_i] <= cfg_sharpen_i;
        end
    end

    // ------------------------------
    // All positions read in parallel
    // ------------------------------
    for (genvar k = 0; k < `QB_COEFS; k++) begin : g_flat
        assign q_o[k*QW +: QW]       = q_mem[k];
        assign iq_o[k*QW +: QW]      = iq_mem[k];
        assign bias_o[k*BW +: BW]    = bias_mem[k];
        assign zthresh_o[k*TW +: TW] = zthresh_mem[k];
        assign sharpen_o[k*HW +: HW] = sharpen_mem[k];
    end

endmodule

//--- design/quant_pkg.sv
// Shared coefficient, level, matrix field and scanner state types
`include "quant_params.svh"

package quant_pkg;

    // ------------------------------
    // Coefficient and result types
    // ------------------------------
    typedef logic signed [`QB_IW-1:0] coef_in_t;
    typedef logic signed [15:0]       level_t;
    typedef logic signed [15:0]       recon_t;

    // ------------------------------
    // Matrix fields
    // ------------------------------
    // Step and inverse step share one type
    typedef logic [15:0] qstep_t;
    typedef logic [31:0] bias_t;
    typedef logic [31:0] thresh_t;
    typedef logic [15:0] sharpen_t;

    // Raster or zigzag position inside a block
    typedef logic [3:0] coef_idx_t;

    // Serial scanner FSM
    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_t;

endpackage

//--- design/quant_top.sv
// Top level with matrix store, block quantizer and coefficient scanner
`timescale 1ns/1ns
`include "quant_params.svh"

module quant_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              cfg_we_i,
    input  quant_pkg::coef_idx_t                              cfg_idx_i,
    input  quant_pkg::qstep_t                                 cfg_q_i,
    input  quant_pkg::qstep_t                                 cfg_iq_i,
    input  quant_pkg::bias_t                                  cfg_bias_i,
    input  quant_pkg::thresh_t                                cfg_zthresh_i,
    input  quant_pkg::sharpen_t                               cfg_sharpen_i,
    input  logic                                              start_i,
    input  logic [`QB_COEFS*$bits(quant_pkg::coef_in_t)-1:0]  blk_i,
    output logic [`QB_COEFS*$bits(quant_pkg::recon_t)-1:0]    rec_o,
    output logic                                              nz_o,
    output logic                                              blk_done_o,
    output logic                                              coef_valid_o,
    output quant_pkg::level_t                                 coef_o,
    output quant_pkg::coef_idx_t                              coef_pos_o,
    output logic                                              coef_last_o
);

    // ------------------------------
    // Matrix and level buses
    // ------------------------------
    logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    q;
    logic [`QB_COEFS*$bits(quant_pkg::qstep_t)-1:0]    iq;
    logic [`QB_COEFS*$bits(quant_pkg::bias_t)-1:0]     bias;
    logic [`QB_COEFS*$bits(quant_pkg::thresh_t)-1:0]   zthresh;
    logic [`QB_COEFS*$bits(quant_pkg::sharpen_t)-1:0]  sharpen;
    logic [`QB_COEFS*$bits(quant_pkg::level_t)-1:0]    zz;

    quant_matrix_store quant_matrix_store_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we_i      (cfg_we_i),
        .cfg_idx_i     (cfg_idx_i),
        .cfg_q_i       (cfg_q_i),
        .cfg_iq_i      (cfg_iq_i),
        .cfg_bias_i    (cfg_bias_i),
        .cfg_zthresh_i (cfg_zthresh_i),
        .cfg_sharpen_i (cfg_sharpen_i),
        .q_o           (q),
        .iq_o          (iq),
        .bias_o        (bias),
        .zthresh_o     (zthresh),
        .sharpen_o     (sharpen)
    );

    quant_block quant_block_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .blk_i     (blk_i),
        .q_i       (q),
        .iq_i      (iq),
        .bias_i    (bias),
        .zthresh_i (zthresh),
        .sharpen_i (sharpen),
        .rec_o     (rec_o),
        .zz_o      (zz),
        .nz_o      (nz_o),
        .done_o    (blk_done_o)
    );

    // Scan starts on the block done pulse
    coef_scan coef_scan_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (blk_done_o),
        .zz_i         (zz),
        .coef_valid_o (coef_valid_o),
        .coef_o       (coef_o),
        .coef_pos_o   (coef_pos_o),
        .coef_last_o  (coef_last_o)
    );

endmodule

//--- files.f
+incdir+include
design/quant_pkg.sv
design/quant_matrix_store.sv
design/quant_block.sv
design/coef_scan.sv
design/quant_top.sv
bench/quant_tb.sv

//--- include/quant_params.svh
// Block size, coefficient width, quantizer shift and level limit
`ifndef QUANT_PARAMS_SVH
`define QUANT_PARAMS_SVH

// ------------------------------
// Block geometry
// ------------------------------
// 4x4 transform block
`define QB_COEFS 16

// Input coefficient width in bits
`define QB_IW 16

// ------------------------------
// Quantizer arithmetic
// ------------------------------
`define QB_SHIFT 17
`define QB_MAX_LEVEL 2047

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the quantizer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary -Wno-fatal --top-module quant_tb -f files.f -Mdir "$build_dir" -o quant_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/quant_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
